//--- fm_reg_pkg.sv
package fm_reg_pkg;

	localparam int num_ch = 6;
	localparam int num_op = 4;
	localparam int num_slot = 24;

	// register group decoded from a host address
	typedef enum logic [3:0] {
		reg_keyon,
		reg_mode,
		reg_dt_mul,
		reg_tl,
		reg_ks_ar,
		reg_am_d1r,
		reg_d2r,
		reg_d1l_rr,
		reg_ssg,
		reg_fnum_lo,
		reg_fnum_hi,
		reg_ch3_lo,
		reg_ch3_hi,
		reg_fb_alg,
		reg_lr_pms,
		reg_none
	} reg_op_e;

	// operator field of a slot is the operator number minus one.
	// entry n is the operator visited at sequence position n, which is also
	// what address bits 3:2 select (offsets +0, +4, +8, +C)
	localparam logic [1:0] slot_order [num_op] = '{2'd0, 2'd2, 2'd1, 2'd3};

endpackage

//--- fm_voice_pkg.sv
package fm_voice_pkg;

	typedef struct packed {
		logic       part;
		logic [7:0] addr;
		logic [7:0] data;
	} host_write_t;

	typedef struct packed {
		logic [2:0] ch;
		logic [1:0] op;
	} slot_t;

	typedef struct packed {
		logic [6:0] tl;
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [1:0] ks;
		logic [4:0] ar;
		logic       amen;
		logic [4:0] d1r;
		logic [4:0] d2r;
		logic [3:0] d1l;
		logic [3:0] rr;
		logic       ssg_en;
		logic [2:0] ssg_eg;
		logic       keyon;
	} op_params_t;

	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  fb;
		logic [2:0]  alg;
		logic [1:0]  rl;
		logic [1:0]  ams;
		logic [2:0]  pms;
		// high byte waits here for the low byte
		logic [2:0]  latch_hi;
		logic [2:0]  latch_block;
	} ch_params_t;

	typedef struct packed {
		logic [2:0]  ch;
		logic [1:0]  op;
		op_params_t  op_par;
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  fb;
		logic [2:0]  alg;
		logic [1:0]  rl;
		logic [1:0]  ams;
		logic [2:0]  pms;
		logic        use_prev1;
		logic        use_prev2;
		logic        use_prevprev1;
		logic        use_internal_x;
		logic        use_internal_y;
	} slot_params_t;

	// update strobe, idle when grp is reg_none
	typedef struct packed {
		fm_reg_pkg::reg_op_e grp;
		logic [1:0]          sel;
		logic [7:0]          data;
	} reg_upd_t;

	localparam op_params_t op_params_rst = '{tl: 7'd127, default: '0};
	localparam ch_params_t ch_params_rst = '{rl: 2'd3, default: '0};

endpackage

//--- fm_slot_counter.sv
`timescale 1ns/1ps

module fm_slot_counter (
	input  logic                clk,
	input  logic                rst_n,
	output fm_voice_pkg::slot_t cur,
	output logic                frame_start
);

	// position in the operator visiting order
	logic [1:0] pos;
	logic [2:0] ch;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos <= 2'd0;
			ch  <= 3'd0;
		end else if (ch == 3'(fm_reg_pkg::num_ch - 1)) begin
			ch  <= 3'd0;
			pos <= (pos == 2'(fm_reg_pkg::num_op - 1)) ? 2'd0 : pos + 2'd1;
		end else begin
			ch <= ch + 3'd1;
		end
	end

	assign cur.ch = ch;
	assign cur.op = fm_reg_pkg::slot_order[pos];
	assign frame_start = (ch == 3'd0) && (pos == 2'd0);

endmodule

//--- fm_write_ctrl.sv
`timescale 1ns/1ps

module fm_write_ctrl (
	input  logic                     clk,
	input  logic                     rst_n,
	input  fm_voice_pkg::host_write_t wr,
	input  logic                     wr_valid,
	output logic                     wr_ready,
	input  fm_voice_pkg::slot_t      cur,
	output fm_voice_pkg::reg_upd_t   op_upd,
	output fm_voice_pkg::reg_upd_t   ch_upd,
	output logic                     ch3_special
);

	fm_reg_pkg::reg_op_e dec_grp, pend_grp;
	logic [2:0] dec_ch, tgt_ch;
	logic [1:0] tgt_op, pend_sel, kon_cnt;
	logic [7:0] pend_data;
	logic busy, accept, ch_hit, slot_hit, is_op_grp, is_ch_grp, is_kon, done;

	// address decode, part 1 only carries 0x30 and up
	always_comb begin
		dec_grp = fm_reg_pkg::reg_none;
		dec_ch  = wr.part ? 3'd3 + {1'b0, wr.addr[1:0]} : {1'b0, wr.addr[1:0]};
		case (wr.addr[7:4])
			4'h2: begin
				if (!wr.part && wr.addr[3:0] == 4'h7) dec_grp = fm_reg_pkg::reg_mode;
				if (!wr.part && wr.addr[3:0] == 4'h8 && wr.data[1:0] != 2'd3)
					dec_grp = fm_reg_pkg::reg_keyon;
				// key-on names its channel in the data byte
				dec_ch = wr.data[2] ? 3'd3 + {1'b0, wr.data[1:0]} : {1'b0, wr.data[1:0]};
			end
			4'h3: dec_grp = fm_reg_pkg::reg_dt_mul;
			4'h4: dec_grp = fm_reg_pkg::reg_tl;
			4'h5: dec_grp = fm_reg_pkg::reg_ks_ar;
			4'h6: dec_grp = fm_reg_pkg::reg_am_d1r;
			4'h7: dec_grp = fm_reg_pkg::reg_d2r;
			4'h8: dec_grp = fm_reg_pkg::reg_d1l_rr;
			4'h9: dec_grp = fm_reg_pkg::reg_ssg;
			4'ha: begin
				case (wr.addr[3:2])
					2'd0: dec_grp = fm_reg_pkg::reg_fnum_lo;
					2'd1: dec_grp = fm_reg_pkg::reg_fnum_hi;
					2'd2: dec_grp = wr.part ? fm_reg_pkg::reg_none : fm_reg_pkg::reg_ch3_lo;
					default: dec_grp = wr.part ? fm_reg_pkg::reg_none : fm_reg_pkg::reg_ch3_hi;
				endcase
				// special frequency registers all belong to channel index 2
				if (wr.addr[3]) dec_ch = 3'd2;
			end
			4'hb: begin
				if (wr.addr[3:2] == 2'd0) dec_grp = fm_reg_pkg::reg_fb_alg;
				if (wr.addr[3:2] == 2'd1) dec_grp = fm_reg_pkg::reg_lr_pms;
			end
			default: dec_grp = fm_reg_pkg::reg_none;
		endcase
		if (wr.addr[7:4] > 4'h2 && wr.addr[1:0] == 2'd3) dec_grp = fm_reg_pkg::reg_none;
	end

	assign accept = wr_valid && wr_ready;
	assign wr_ready = !busy;

	assign is_op_grp = pend_grp inside {fm_reg_pkg::reg_dt_mul, fm_reg_pkg::reg_tl,
		fm_reg_pkg::reg_ks_ar, fm_reg_pkg::reg_am_d1r, fm_reg_pkg::reg_d2r,
		fm_reg_pkg::reg_d1l_rr, fm_reg_pkg::reg_ssg};
	assign is_ch_grp = pend_grp inside {fm_reg_pkg::reg_fnum_lo, fm_reg_pkg::reg_fnum_hi,
		fm_reg_pkg::reg_ch3_lo, fm_reg_pkg::reg_ch3_hi, fm_reg_pkg::reg_fb_alg,
		fm_reg_pkg::reg_lr_pms};
	assign is_kon = pend_grp == fm_reg_pkg::reg_keyon;

	assign ch_hit = busy && cur.ch == tgt_ch;
	assign slot_hit = ch_hit && cur.op == tgt_op;

	// key-on finishes once all four operators of the channel have been seen
	assign done = busy && (!(is_op_grp || is_ch_grp || is_kon) ||
		(is_op_grp && slot_hit) || (is_ch_grp && ch_hit) ||
		(is_kon && ch_hit && kon_cnt == 2'd3));

	assign op_upd.grp = ((is_op_grp && slot_hit) || (is_kon && ch_hit)) ?
		pend_grp : fm_reg_pkg::reg_none;
	assign op_upd.sel = pend_sel;
	assign op_upd.data = pend_data;
	assign ch_upd.grp = (is_ch_grp && ch_hit) ? pend_grp : fm_reg_pkg::reg_none;
	assign ch_upd.sel = pend_sel;
	assign ch_upd.data = pend_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy        <= 1'b0;
			pend_grp    <= fm_reg_pkg::reg_none;
			kon_cnt     <= 2'd0;
			ch3_special <= 1'b0;
		end else begin
			if (accept) begin
				busy     <= 1'b1;
				pend_grp <= dec_grp;
				kon_cnt  <= 2'd0;
			end else if (done) begin
				busy <= 1'b0;
			end
			if (is_kon && ch_hit) kon_cnt <= kon_cnt + 2'd1;
			if (busy && pend_grp == fm_reg_pkg::reg_mode) ch3_special <= pend_data[6];
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pend_data <= wr.data;
			pend_sel  <= wr.addr[1:0];
			tgt_ch    <= dec_ch;
			tgt_op    <= fm_reg_pkg::slot_order[wr.addr[3:2]];
		end
	end

endmodule

//--- fm_op_regs.sv
`timescale 1ns/1ps

module fm_op_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  fm_voice_pkg::slot_t      cur,
	input  fm_voice_pkg::reg_upd_t   op_upd,
	output fm_voice_pkg::op_params_t op_rd
);

	fm_voice_pkg::op_params_t mem [fm_reg_pkg::num_slot];
	fm_voice_pkg::op_params_t rd_val;
	fm_voice_pkg::op_params_t wr_val;
	logic [4:0] idx;
	logic [7:0] d;

	// entries laid out operator-major, six channels each
	assign idx = 5'(cur.op) * 5'(fm_reg_pkg::num_ch) + 5'(cur.ch);
	assign rd_val = mem[idx];
	assign d = op_upd.data;

	// replace the fields of the addressed group
	always_comb begin
		wr_val = rd_val;
		case (op_upd.grp)
			fm_reg_pkg::reg_dt_mul: begin
				wr_val.dt1 = d[6:4];
				wr_val.mul = d[3:0];
			end
			fm_reg_pkg::reg_tl: wr_val.tl = d[6:0];
			fm_reg_pkg::reg_ks_ar: begin
				wr_val.ks = d[7:6];
				wr_val.ar = d[4:0];
			end
			fm_reg_pkg::reg_am_d1r: begin
				wr_val.amen = d[7];
				wr_val.d1r  = d[4:0];
			end
			fm_reg_pkg::reg_d2r: wr_val.d2r = d[4:0];
			fm_reg_pkg::reg_d1l_rr: begin
				wr_val.d1l = d[7:4];
				wr_val.rr  = d[3:0];
			end
			fm_reg_pkg::reg_ssg: begin
				wr_val.ssg_en = d[3];
				wr_val.ssg_eg = d[2:0];
			end
			// bits 7:4 hold one key bit per operator
			fm_reg_pkg::reg_keyon: wr_val.keyon = d[3'd4 + 3'(cur.op)];
			default: wr_val = rd_val;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < fm_reg_pkg::num_slot; i++) begin
				mem[i] <= fm_voice_pkg::op_params_rst;
			end
		end else begin
			mem[idx] <= wr_val;
		end
	end

	always_ff @(posedge clk) begin
		op_rd <= wr_val;
	end

endmodule

//--- fm_ch_regs.sv
`timescale 1ns/1ps

module fm_ch_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  fm_voice_pkg::slot_t      cur,
	input  fm_voice_pkg::reg_upd_t   ch_upd,
	output fm_voice_pkg::ch_params_t ch_rd,
	output logic [2:0][13:0]         ch3_fnum
);

	fm_voice_pkg::ch_params_t mem [fm_reg_pkg::num_ch];
	fm_voice_pkg::ch_params_t rd_val;
	fm_voice_pkg::ch_params_t wr_val;
	logic [2:0] c3_latch_hi;
	logic [2:0] c3_latch_block;
	logic [7:0] d;

	assign rd_val = mem[cur.ch];
	assign d = ch_upd.data;

	always_comb begin
		wr_val = rd_val;
		case (ch_upd.grp)
			fm_reg_pkg::reg_fnum_hi: begin
				wr_val.latch_block = d[5:3];
				wr_val.latch_hi    = d[2:0];
			end
			// low byte commits the latched high byte
			fm_reg_pkg::reg_fnum_lo: begin
				wr_val.block = rd_val.latch_block;
				wr_val.fnum  = {rd_val.latch_hi, d};
			end
			fm_reg_pkg::reg_fb_alg: begin
				wr_val.fb  = d[5:3];
				wr_val.alg = d[2:0];
			end
			fm_reg_pkg::reg_lr_pms: begin
				wr_val.rl  = d[7:6];
				wr_val.ams = d[5:4];
				wr_val.pms = d[2:0];
			end
			default: wr_val = rd_val;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < fm_reg_pkg::num_ch; i++) begin
				mem[i] <= fm_voice_pkg::ch_params_rst;
			end
			c3_latch_hi    <= 3'd0;
			c3_latch_block <= 3'd0;
			ch3_fnum       <= '0;
		end else begin
			mem[cur.ch] <= wr_val;
			if (ch_upd.grp == fm_reg_pkg::reg_ch3_hi) begin
				c3_latch_block <= d[5:3];
				c3_latch_hi    <= d[2:0];
			end
			// sel 0..2 is operator 1..3
			if (ch_upd.grp == fm_reg_pkg::reg_ch3_lo && ch_upd.sel != 2'd3) begin
				ch3_fnum[ch_upd.sel] <= {c3_latch_block, c3_latch_hi, d};
			end
		end
	end

	always_ff @(posedge clk) begin
		ch_rd <= wr_val;
	end

endmodule

//--- fm_slot_out.sv
`timescale 1ns/1ps

module fm_slot_out (
	input  logic                       clk,
	input  logic                       rst_n,
	input  fm_voice_pkg::slot_t        cur,
	input  fm_voice_pkg::op_params_t   op_rd,
	input  fm_voice_pkg::ch_params_t   ch_rd,
	input  logic [2:0][13:0]           ch3_fnum,
	input  logic                       ch3_special,
	output fm_voice_pkg::slot_params_t slot_out,
	output logic                       slot_out_valid
);

	// slot that op_rd and ch_rd belong to
	fm_voice_pkg::slot_t cur_d;
	fm_voice_pkg::slot_params_t nxt;
	logic [7:0] alg_hot;
	logic s1, s2, s3, s4, spec, rd_valid;

	assign s1 = cur_d.op == 2'd0;
	assign s2 = cur_d.op == 2'd1;
	assign s3 = cur_d.op == 2'd2;
	assign s4 = cur_d.op == 2'd3;
	assign alg_hot = 8'd1 << ch_rd.alg;
	assign spec = ch3_special && cur_d.ch == 3'd2 && !s4;

	always_comb begin
		nxt.ch = cur_d.ch;
		nxt.op = cur_d.op;
		nxt.op_par = op_rd;
		{nxt.block, nxt.fnum} = spec ? ch3_fnum[cur_d.op] : {ch_rd.block, ch_rd.fnum};
		nxt.fb = ch_rd.fb;
		nxt.alg = ch_rd.alg;
		nxt.rl = ch_rd.rl;
		nxt.ams = ch_rd.ams;
		nxt.pms = ch_rd.pms;
		// modulator sources per algorithm and operator
		nxt.use_prevprev1 = s1 | (s3 & alg_hot[5]);
		nxt.use_prev2 = (s3 & (|alg_hot[2:0])) | (s4 & alg_hot[3]);
		nxt.use_internal_x = s4 & alg_hot[2];
		nxt.use_internal_y = s4 & (|{alg_hot[4:3], alg_hot[1:0]});
		nxt.use_prev1 = s1 | (s3 & alg_hot[1]) | (s2 & (|{alg_hot[6:3], alg_hot[0]})) |
			(s4 & (|{alg_hot[5], alg_hot[2]}));
	end

	always_ff @(posedge clk) begin
		cur_d    <= cur;
		slot_out <= nxt;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid       <= 1'b0;
			slot_out_valid <= 1'b0;
		end else begin
			rd_valid       <= 1'b1;
			slot_out_valid <= rd_valid;
		end
	end

endmodule

//--- fm_reg_top.sv
`timescale 1ns/1ps

module fm_reg_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  fm_voice_pkg::host_write_t  wr,
	input  logic                       wr_valid,
	output logic                       wr_ready,
	output fm_voice_pkg::slot_params_t slot_out,
	output logic                       slot_out_valid
);

	fm_voice_pkg::slot_t cur;
	logic frame_start;
	fm_voice_pkg::reg_upd_t op_upd;
	fm_voice_pkg::reg_upd_t ch_upd;
	logic ch3_special;
	fm_voice_pkg::op_params_t op_rd;
	fm_voice_pkg::ch_params_t ch_rd;
	logic [2:0][13:0] ch3_fnum;

	fm_slot_counter u_cnt (
		.clk         (clk),
		.rst_n       (rst_n),
		.cur         (cur),
		.frame_start (frame_start)
	);

	fm_write_ctrl u_wr (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.wr_valid    (wr_valid),
		.wr_ready    (wr_ready),
		.cur         (cur),
		.op_upd      (op_upd),
		.ch_upd      (ch_upd),
		.ch3_special (ch3_special)
	);

	fm_op_regs u_op (
		.clk    (clk),
		.rst_n  (rst_n),
		.cur    (cur),
		.op_upd (op_upd),
		.op_rd  (op_rd)
	);

	fm_ch_regs u_ch (
		.clk      (clk),
		.rst_n    (rst_n),
		.cur      (cur),
		.ch_upd   (ch_upd),
		.ch_rd    (ch_rd),
		.ch3_fnum (ch3_fnum)
	);

	fm_slot_out u_out (
		.clk            (clk),
		.rst_n          (rst_n),
		.cur            (cur),
		.op_rd          (op_rd),
		.ch_rd          (ch_rd),
		.ch3_fnum       (ch3_fnum),
		.ch3_special    (ch3_special),
		.slot_out       (slot_out),
		.slot_out_valid (slot_out_valid)
	);

endmodule

//--- fm_reg_assert.sv
`timescale 1ns/1ps

module fm_reg_assert (
	input logic                     clk,
	input logic                     rst_n,
	input fm_voice_pkg::host_write_t wr,
	input logic                     wr_valid,
	input logic                     wr_ready,
	input fm_voice_pkg::slot_t      cur,
	input logic                     frame_start
);

	logic [5:0] wait_cnt;

	// operator visiting order 1, 3, 2, 4
	function automatic logic [1:0] next_op(input logic [1:0] op);
		case (op)
			2'd0: return 2'd2;
			2'd2: return 2'd1;
			2'd1: return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n || wr_ready) begin
			wait_cnt <= 6'd0;
		end else if (wait_cnt != 6'h3f) begin
			wait_cnt <= wait_cnt + 6'd1;
		end
	end

	a_wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wr_valid && !wr_ready |=> $stable(wr))
		else $error("host write changed while stalled");

	a_ready_back: assert property (@(posedge clk) disable iff (!rst_n) wait_cnt <= 6'd25)
		else $error("wr_ready low for more than 25 cycles");

	a_ch_step: assert property (@(posedge clk) disable iff (!rst_n)
		cur.ch != 3'd5 |=> cur.ch == $past(cur.ch) + 3'd1 && cur.op == $past(cur.op))
		else $error("slot channel did not advance");

	a_op_step: assert property (@(posedge clk) disable iff (!rst_n)
		cur.ch == 3'd5 |=> cur.ch == 3'd0 && cur.op == next_op($past(cur.op)))
		else $error("slot operator out of order");

	a_frame: assert property (@(posedge clk) disable iff (!rst_n)
		frame_start == (cur.ch == 3'd0 && cur.op == 2'd0))
		else $error("frame_start does not mark channel 0 operator 1");

endmodule

bind fm_reg_top fm_reg_assert fm_reg_assert_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.wr          (wr),
	.wr_valid    (wr_valid),
	.wr_ready    (wr_ready),
	.cur         (cur),
	.frame_start (frame_start)
);

//--- fm_reg_tb.sv
`timescale 1ns/1ps

module fm_reg_tb;

	logic clk;
	logic rst_n;
	fm_voice_pkg::host_write_t wr;
	logic wr_valid;
	logic wr_ready;
	fm_voice_pkg::slot_params_t slot_out;
	logic slot_out_valid;

	// reference model of the register contents
	fm_voice_pkg::op_params_t exp_op [6][4];
	fm_voice_pkg::ch_params_t exp_ch [6];
	logic [13:0] sp_fnum [3];
	logic [5:0] sp_latch;
	logic special;

	int errors;
	int checks;
	int quiet;
	bit timed_out;
	// slot expected next on slot_out
	int mon_ch;
	int mon_pos;

	// part, address, data
	localparam int n_wr = 32;
	localparam logic [16:0] wr_table [n_wr] = '{
		{1'b0, 8'h30, 8'h71}, {1'b1, 8'h44, 8'h22}, {1'b0, 8'h5a, 8'hdf},
		{1'b1, 8'h6d, 8'h8a}, {1'b0, 8'h71, 8'h13}, {1'b1, 8'h82, 8'h5c},
		{1'b0, 8'h99, 8'h0b}, {1'b1, 8'h4f, 8'h11},
		// high byte first, then low byte commits
		{1'b0, 8'ha5, 8'h2d}, {1'b0, 8'ha1, 8'h9c}, {1'b1, 8'ha6, 8'h15},
		{1'b1, 8'ha2, 8'h40}, {1'b0, 8'ha6, 8'h1a}, {1'b0, 8'ha2, 8'h33},
		// channel 3 special frequencies
		{1'b0, 8'hac, 8'h22}, {1'b0, 8'ha8, 8'h11}, {1'b0, 8'had, 8'h0b},
		{1'b0, 8'ha9, 8'h55}, {1'b0, 8'hae, 8'h3f}, {1'b0, 8'haa, 8'hee},
		{1'b0, 8'h27, 8'h40}, {1'b0, 8'h27, 8'h00},
		{1'b0, 8'hb0, 8'h3d}, {1'b0, 8'hb1, 8'h0a}, {1'b0, 8'hb2, 8'h1b},
		{1'b1, 8'hb0, 8'h20}, {1'b1, 8'hb1, 8'h01}, {1'b1, 8'hb2, 8'h3c},
		{1'b0, 8'hb0, 8'h06}, {1'b0, 8'hb1, 8'h07}, {1'b1, 8'hb4, 8'h75},
		{1'b0, 8'h28, 8'hf5}
	};

	fm_reg_top fm_reg_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.wr             (wr),
		.wr_valid       (wr_valid),
		.wr_ready       (wr_ready),
		.slot_out       (slot_out),
		.slot_out_valid (slot_out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timeout while waiting for %s", what);
	endtask

	// offsets +0, +4, +8, +C are operators 1, 3, 2, 4
	function automatic int visit_op(input int pos);
		return (pos == 1) ? 2 : (pos == 2) ? 1 : pos;
	endfunction

	// modulator flags {prev1, prev2, prevprev1, internal_x, internal_y}
	function automatic logic [4:0] alg_flags(input logic [2:0] alg, input logic [1:0] op);
		logic [4:0] f;
		f = 5'b00000;
		case (op)
			2'd0: f = 5'b10100;
			2'd1: if (alg inside {3'd0, 3'd3, 3'd4, 3'd5, 3'd6}) f = 5'b10000;
			2'd2: begin
				if (alg == 3'd0 || alg == 3'd2) f = 5'b01000;
				if (alg == 3'd1) f = 5'b11000;
				if (alg == 3'd5) f = 5'b00100;
			end
			default: begin
				if (alg == 3'd0 || alg == 3'd1 || alg == 3'd4) f = 5'b00001;
				if (alg == 3'd2) f = 5'b10010;
				if (alg == 3'd3) f = 5'b01001;
				if (alg == 3'd5) f = 5'b10000;
			end
		endcase
		return f;
	endfunction

	function automatic fm_voice_pkg::slot_params_t expect_slot(input int c, input int o);
		fm_voice_pkg::slot_params_t s;
		s.ch = 3'(c);
		s.op = 2'(o);
		s.op_par = exp_op[c][o];
		if (special && c == 2 && o < 3) begin
			{s.block, s.fnum} = sp_fnum[o];
		end else begin
			s.block = exp_ch[c].block;
			s.fnum = exp_ch[c].fnum;
		end
		s.fb = exp_ch[c].fb;
		s.alg = exp_ch[c].alg;
		s.rl = exp_ch[c].rl;
		s.ams = exp_ch[c].ams;
		s.pms = exp_ch[c].pms;
		{s.use_prev1, s.use_prev2, s.use_prevprev1, s.use_internal_x, s.use_internal_y} =
			alg_flags(exp_ch[c].alg, 2'(o));
		return s;
	endfunction

	task automatic model_write(input logic part, input logic [7:0] a, input logic [7:0] d);
		int c;
		int o;
		int kc;
		c = (part ? 3 : 0) + int'(a[1:0]);
		o = visit_op(int'(a[3:2]));
		if (a == 8'h27 && !part) special = d[6];
		if (a == 8'h28 && !part && d[1:0] != 2'd3) begin
			kc = (d[2] ? 3 : 0) + int'(d[1:0]);
			for (int i = 0; i < 4; i++) exp_op[kc][i].keyon = d[4 + i];
		end
		if (a[7:4] >= 4'h3 && a[1:0] != 2'd3) begin
			case (a[7:4])
				4'h3: {exp_op[c][o].dt1, exp_op[c][o].mul} = {d[6:4], d[3:0]};
				4'h4: exp_op[c][o].tl = d[6:0];
				4'h5: {exp_op[c][o].ks, exp_op[c][o].ar} = {d[7:6], d[4:0]};
				4'h6: {exp_op[c][o].amen, exp_op[c][o].d1r} = {d[7], d[4:0]};
				4'h7: exp_op[c][o].d2r = d[4:0];
				4'h8: {exp_op[c][o].d1l, exp_op[c][o].rr} = d;
				4'h9: {exp_op[c][o].ssg_en, exp_op[c][o].ssg_eg} = d[3:0];
				4'ha: begin
					if (a[3:2] == 2'd0) begin
						exp_ch[c].block = exp_ch[c].latch_block;
						exp_ch[c].fnum = {exp_ch[c].latch_hi, d};
					end
					if (a[3:2] == 2'd1) {exp_ch[c].latch_block, exp_ch[c].latch_hi} = d[5:0];
					if (a[3:2] == 2'd2 && !part) sp_fnum[a[1:0]] = {sp_latch, d};
					if (a[3:2] == 2'd3 && !part) sp_latch = d[5:0];
				end
				4'hb: begin
					if (a[3:2] == 2'd0) {exp_ch[c].fb, exp_ch[c].alg} = d[5:0];
					if (a[3:2] == 2'd1) begin
						exp_ch[c].rl = d[7:6];
						exp_ch[c].ams = d[5:4];
						exp_ch[c].pms = d[2:0];
					end
				end
				default: ;
			endcase
		end
	endtask

	// waits until every slot has been compared at least once since the last write
	task automatic wait_quiet();
		int n;
		n = 0;
		while (quiet < 60 && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (quiet < 60) report_timeout("the bank to settle after a write");
	endtask

	// holds valid until the bank takes the write
	task automatic send_write(input logic part, input logic [7:0] a, input logic [7:0] d);
		int n;
		n = 0;
		@(posedge clk);
		wr <= '{part: part, addr: a, data: d};
		wr_valid <= 1'b1;
		@(negedge clk);
		while (!wr_ready && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (!wr_ready) begin
			report_timeout("wr_ready with a write pending");
		end else begin
			@(posedge clk);
			wr_valid <= 1'b0;
			model_write(part, a, d);
		end
	endtask

	task automatic write_reg(input logic part, input logic [7:0] a, input logic [7:0] d);
		send_write(part, a, d);
		if (!timed_out) wait_quiet();
	endtask

	// slot output monitor
	always @(negedge clk) begin
		if (!rst_n || wr_valid || !wr_ready) begin
			quiet = 0;
		end else if (quiet < 1000) begin
			quiet++;
		end
		if (!rst_n) begin
			mon_ch = 0;
			mon_pos = 0;
		end else if (slot_out_valid) begin
			if (quiet >= 30) begin
				checks++;
				check($sformatf("slot_out ch%0d op%0d", mon_ch, visit_op(mon_pos) + 1),
					slot_out, expect_slot(mon_ch, visit_op(mon_pos)));
			end
			if (mon_ch == 5) begin
				mon_ch = 0;
				mon_pos = (mon_pos + 1) % 4;
			end else begin
				mon_ch++;
			end
		end
	end

	initial begin
		logic [2:0] rc;
		logic [7:0] kd;
		errors = 0;
		checks = 0;
		quiet = 0;
		timed_out = 1'b0;
		void'($urandom(32'h232ddcab));
		rst_n = 1'b0;
		wr = '0;
		wr_valid = 1'b0;
		special = 1'b0;
		sp_latch = '0;
		for (int i = 0; i < 3; i++) sp_fnum[i] = '0;
		for (int c = 0; c < 6; c++) begin
			exp_ch[c] = '0;
			exp_ch[c].rl = 2'd3;
			for (int o = 0; o < 4; o++) begin
				exp_op[c][o] = '0;
				exp_op[c][o].tl = 7'd127;
			end
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check("wr_ready", wr_ready, 1'b1);
		check("slot_out_valid", slot_out_valid, 1'b0);
		// channel 0 operator 1 reaches the output two cycles after reset
		@(negedge clk);
		check("slot_out_valid", slot_out_valid, 1'b0);
		@(negedge clk);
		check("slot_out_valid", slot_out_valid, 1'b1);
		check("slot_out.ch", slot_out.ch, 3'd0);
		check("slot_out.op", slot_out.op, 2'd0);
		wait_quiet();
		for (int i = 0; i < n_wr && !timed_out; i++) begin
			write_reg(wr_table[i][16], wr_table[i][15:8], wr_table[i][7:0]);
		end
		// special mode on again, then random key-on patterns
		if (!timed_out) write_reg(1'b0, 8'h27, 8'h40);
		for (int i = 0; i < 8 && !timed_out; i++) begin
			rc = 3'($urandom % 6);
			kd = {4'($urandom), 1'b0, rc >= 3'd3, 2'(rc % 3'd3)};
			// even writes go out back to back with the next one and stall on wr_ready
			if (i % 2 == 0) begin
				send_write(1'b0, 8'h28, kd);
			end else begin
				write_reg(1'b0, 8'h28, kd);
			end
		end
		$display("errors %0d checks %0d", errors, checks);
		if (errors == 0 && checks > 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- build.f
fm_reg_pkg.sv
fm_voice_pkg.sv
fm_slot_counter.sv
fm_write_ctrl.sv
fm_op_regs.sv
fm_ch_regs.sv
fm_slot_out.sv
fm_reg_top.sv
fm_reg_assert.sv
fm_reg_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the register bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module fm_reg_tb -o fm_reg_sim
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

out=$(./obj_dir/fm_reg_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^All tests passed$"; then
	exit 0
fi
exit 1
